/* tests/program_input.txt */
# P <byte address hex> <instruction hex> [assembly]
# E <test name> <store address hex> <store data hex> <byte enables hex>
P 00 10000093 addi x1, x0, 0x100
P 04 00700113 addi x2, x0, 7
P 08 ffd00193 addi x3, x0, -3
P 0c 40310233 sub x4, x2, x3
P 10 0040a023 sw x4, 0(x1)
P 14 0021a2b3 slt x5, x3, x2
P 18 4051d333 sra x6, x3, x5
P 1c 0060a223 sw x6, 4(x1)
P 20 0050a423 sw x5, 8(x1)
P 24 12345437 lui x8, 0x12345
P 28 67846413 ori x8, x8, 0x678
P 2c 0080a623 sw x8, 12(x1)
P 30 00c0a483 lw x9, 12(x1)
P 34 00148493 addi x9, x9, 1
P 38 0090a823 sw x9, 16(x1)
P 3c f8000513 addi x10, x0, -128
P 40 00a08aa3 sb x10, 21(x1)
P 44 01508583 lb x11, 21(x1)
P 48 0150c603 lbu x12, 21(x1)
P 4c 00b0ac23 sw x11, 24(x1)
P 50 00c0ae23 sw x12, 28(x1)
P 54 00310463 beq x2, x3, +8
P 58 0220a023 sw x2, 32(x1)
P 5c 0021c463 blt x3, x2, +8
P 60 0200a223 sw x0, 36(x1)
P 64 0021d463 bge x3, x2, +8
P 68 00311463 bne x2, x3, +8
P 6c 0200a423 sw x0, 40(x1)
P 70 008006ef jal x13, +8
P 74 0200a623 sw x0, 44(x1)
P 78 00000717 auipc x14, 0
P 7c 00e687b3 add x15, x13, x14
P 80 02f0a423 sw x15, 40(x1)
P 84 0000006f jal x0, 0
E alu_sub 100 0000000a f
E alu_sra 104 fffffffe f
E alu_slt 108 00000001 f
E fwd_lui_ori 10c 12345678 f
E load_use 110 12345679 f
E sb_lane 114 80808080 2
E lb_sign 118 ffffff80 f
E lbu_zero 11c 00000080 f
E branch_path 120 00000007 f
E jal_link 128 000000ec f

/* flist.f */
logic/rv32i_types.sv
logic/pipe_ctrl_pkg.sv
logic/pipe_reg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_stage.sv
logic/hazard_unit.sv
logic/datapath.sv
tests/tb_checker.sv
tests/tb_datapath.sv

/* Makefile */
sim:
	verilator --binary --timing --assert -f flist.f --top-module tb_datapath -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tb_datapath.sv */
module tb_datapath;

    timeunit 1ns;
    timeprecision 1ps;

    import rv32i_types::*;

    localparam rv32i_word   RESET_PC = 32'h0000_0000;
    localparam int unsigned SEED     = 32'h44a9_edbb;

    logic       clk;
    logic       arst_n;
    rv32i_word  i_mem_rdata;
    logic       i_mem_resp;
    rv32i_word  d_mem_rdata;
    logic       d_mem_resp;
    rv32i_word  i_mem_address;
    logic       i_mem_read;
    rv32i_word  d_mem_address;
    rv32i_word  d_mem_wdata;
    logic       d_mem_read;
    logic       d_mem_write;
    logic [3:0] d_mbe;

    rv32i_word  imem [rv32i_word];
    rv32i_word  dmem [rv32i_word];
    int         prog_len;
    int         cycle_limit;
    int         cycles;
    int         i_wait;
    int         d_wait;
    logic       i_active;
    logic       d_active;
    logic       loaded;
    logic       file_ok;
    int         err_count;
    int         seen_count;
    int         expect_count;
    logic       all_seen;

    datapath #(.RESET_PC(RESET_PC)) u_dut (
        .clk(clk), .arst_n_i(arst_n),
        .i_mem_rdata_i(i_mem_rdata), .i_mem_resp_i(i_mem_resp),
        .d_mem_rdata_i(d_mem_rdata), .d_mem_resp_i(d_mem_resp),
        .i_mem_address_o(i_mem_address), .i_mem_read_o(i_mem_read),
        .d_mem_address_o(d_mem_address), .d_mem_wdata_o(d_mem_wdata),
        .d_mem_read_o(d_mem_read), .d_mem_write_o(d_mem_write), .d_mbe_o(d_mbe)
    );

    tb_checker u_check (
        .clk(clk), .arst_n_i(arst_n), .i_mem_resp_i(i_mem_resp),
        .d_mem_write_i(d_mem_write), .d_mem_resp_i(d_mem_resp),
        .d_mem_address_i(d_mem_address), .d_mem_wdata_i(d_mem_wdata), .d_mbe_i(d_mbe),
        .err_count_o(err_count), .seen_count_o(seen_count),
        .expect_count_o(expect_count), .all_seen_o(all_seen)
    );

    always #4 clk = ~clk;

    // unloaded words carry opcode zero and decode as bubbles
    function automatic rv32i_word imem_read(input rv32i_word addr);
        if (imem.exists(addr)) begin
            return imem[addr];
        end
        return {addr[24:0] ^ {18'd0, addr[31:25]}, 7'b0000000};
    endfunction

    function automatic rv32i_word dmem_read(input rv32i_word addr);
        if (dmem.exists(addr)) begin
            return dmem[addr];
        end
        return addr ^ 32'hc3a5_96e1;
    endfunction

    task automatic dmem_write(input rv32i_word addr, input rv32i_word data,
                              input logic [3:0] mbe);
        rv32i_word word;
        word = dmem_read(addr);
        for (int b = 0; b < 4; b++) begin
            if (mbe[b]) begin
                word[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        dmem[addr] = word;
    endtask

    task automatic load_file(output logic ok);
        int              fd;
        string           line;
        logic [8*24-1:0] name_buf;
        rv32i_word       addr;
        rv32i_word       data;
        logic [3:0]      mbe;
        ok = 1'b0;
        fd = $fopen("tests/program_input.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) == 0) begin
                    break;
                end
                if (line.len() > 0 && line[0] == "P") begin
                    if ($sscanf(line, "P %h %h", addr, data) == 2) begin
                        imem[addr] = data;
                        prog_len = prog_len + 1;
                    end
                end else if (line.len() > 0 && line[0] == "E") begin
                    if ($sscanf(line, "E %s %h %h %h", name_buf, addr, data, mbe) == 4) begin
                        u_check.expect_store($sformatf("%0s", name_buf), addr, data, mbe);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // instruction port with 0 to 3 cycles per request
    always @(posedge clk) begin
        #1;
        if (i_mem_resp) begin
            i_active = 1'b0;
        end
        i_mem_resp = 1'b0;
        if (i_mem_read) begin
            if (!i_active) begin
                i_active = 1'b1;
                i_wait   = $urandom % 4;
            end
            if (i_wait == 0) begin
                i_mem_resp  = 1'b1;
                i_mem_rdata = imem_read(i_mem_address);
            end else begin
                i_wait = i_wait - 1;
            end
        end else begin
            i_active = 1'b0;
        end
    end

    // data port merging writes by byte enable
    always @(posedge clk) begin
        #1;
        if (d_mem_resp) begin
            d_active = 1'b0;
        end
        d_mem_resp = 1'b0;
        if (d_mem_read || d_mem_write) begin
            if (!d_active) begin
                d_active = 1'b1;
                d_wait   = $urandom % 4;
            end
            if (d_wait == 0) begin
                d_mem_resp = 1'b1;
                if (d_mem_write) begin
                    dmem_write(d_mem_address, d_mem_wdata, d_mbe);
                end
                d_mem_rdata = dmem_read(d_mem_address);
            end else begin
                d_wait = d_wait - 1;
            end
        end else begin
            d_active = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (loaded && arst_n) begin
            cycles = cycles + 1;
            if (cycles >= cycle_limit) begin
                $display("timeout after %0d cycles, expected stores still missing", cycles);
                $display("errors: %0d, stores matched: %0d of %0d",
                         err_count, seen_count, expect_count);
                $display("Simulation finished: FAIL");
                $finish;
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        clk         = 1'b0;
        arst_n      = 1'b0;
        i_mem_rdata = '0;
        i_mem_resp  = 1'b0;
        d_mem_rdata = '0;
        d_mem_resp  = 1'b0;
        i_active    = 1'b0;
        d_active    = 1'b0;
        i_wait      = 0;
        d_wait      = 0;
        prog_len    = 0;
        cycles      = 0;
        loaded      = 1'b0;
        load_file(file_ok);
        if (!file_ok) begin
            $display("could not open tests/program_input.txt");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            cycle_limit = 40 * prog_len + 200;
            loaded      = 1'b1;
            repeat (5) @(posedge clk);
            #1;
            arst_n = 1'b1;
            wait (all_seen);
            // give a stray store time to show up
            repeat (20) @(posedge clk);
            $display("errors: %0d, stores matched: %0d of %0d",
                     err_count, seen_count, expect_count);
            if (err_count == 0 && all_seen) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

/* tests/tb_checker.sv */
module tb_checker (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        i_mem_resp_i,
    input  logic        d_mem_write_i,
    input  logic        d_mem_resp_i,
    input  logic [31:0] d_mem_address_i,
    input  logic [31:0] d_mem_wdata_i,
    input  logic [3:0]  d_mbe_i,
    output int          err_count_o,
    output int          seen_count_o,
    output int          expect_count_o,
    output logic        all_seen_o
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mbe;
    } store_t;

    store_t expected [$];
    string  names [$];
    store_t actual;
    int     errors = 0;
    int     seen = 0;
    int     expect_count = 0;

    task automatic expect_store(input string name, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] mbe);
        store_t s;
        s.addr = addr;
        s.data = data;
        s.mbe  = mbe;
        expected.push_back(s);
        names.push_back(name);
        expect_count = expect_count + 1;
    endtask

    assign actual = '{addr: d_mem_address_i, data: d_mem_wdata_i, mbe: d_mbe_i};

    // a store counts on the edge that moves it out of MEM
    always @(posedge clk) begin
        if (arst_n_i && d_mem_write_i && d_mem_resp_i && i_mem_resp_i) begin
            if (seen >= expect_count) begin
                $display("unexpected store to address %08h with data %08h and mbe %b",
                         actual.addr, actual.data, actual.mbe);
                errors = errors + 1;
            end else begin
                if (actual != expected[seen]) begin
                    $display("CHECK FAILED %0s: expected addr %08h data %08h mbe %b, %s",
                             names[seen], expected[seen].addr, expected[seen].data,
                             expected[seen].mbe,
                             $sformatf("actual addr %08h data %08h mbe %b",
                                       actual.addr, actual.data, actual.mbe));
                    errors = errors + 1;
                end
                seen = seen + 1;
            end
        end
    end

    assign err_count_o    = errors;
    assign seen_count_o   = seen;
    assign expect_count_o = expect_count;
    assign all_seen_o     = (expect_count > 0) && (seen == expect_count);

endmodule

/* logic/datapath.sv */
module datapath #(
    parameter rv32i_types::rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  rv32i_types::rv32i_word i_mem_rdata_i,
    input  logic                   i_mem_resp_i,
    input  rv32i_types::rv32i_word d_mem_rdata_i,
    input  logic                   d_mem_resp_i,
    output rv32i_types::rv32i_word i_mem_address_o,
    output logic                   i_mem_read_o,
    output rv32i_types::rv32i_word d_mem_address_o,
    output rv32i_types::rv32i_word d_mem_wdata_o,
    output logic                   d_mem_read_o,
    output logic                   d_mem_write_o,
    output logic [3:0]             d_mbe_o
);

    import rv32i_types::*;
    import pipe_ctrl_pkg::*;

    if_id_t     if_id_d;
    if_id_t     if_id_q;
    id_ex_t     id_ex_d;
    id_ex_t     id_ex_q;
    ex_mem_t    ex_mem_d;
    ex_mem_t    ex_mem_q;
    mem_wb_t    mem_wb_d;
    mem_wb_t    mem_wb_q;
    pcmux_sel_t pcmux_sel;
    rv32i_word  target;
    fwd_sel_t   fwd_a;
    fwd_sel_t   fwd_b;
    logic [4:0] id_rs1;
    logic [4:0] id_rs2;
    logic       redirect;
    logic       stall;
    logic       freeze;
    logic       front_hold;
    logic       if_id_flush;
    logic       id_ex_flush;

    assign front_hold  = freeze || stall;
    // a frozen redirect waits in EX and flushes once the pipe moves
    assign if_id_flush = redirect && !freeze;
    assign id_ex_flush = (redirect || stall) && !freeze;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .arst_n_i(arst_n_i), .hold_i(front_hold),
        .pcmux_sel_i(pcmux_sel), .target_i(target), .i_mem_rdata_i(i_mem_rdata_i),
        .i_mem_address_o(i_mem_address_o), .i_mem_read_o(i_mem_read_o), .if_id_o(if_id_d)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .arst_n_i(arst_n_i), .load_i(!front_hold), .flush_i(if_id_flush),
        .d_i(if_id_d), .q_o(if_id_q)
    );

    decode_stage u_decode (
        .clk(clk), .arst_n_i(arst_n_i), .if_id_i(if_id_q), .wb_i(mem_wb_q),
        .id_ex_o(id_ex_d), .rs1_o(id_rs1), .rs2_o(id_rs2)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .arst_n_i(arst_n_i), .load_i(!freeze), .flush_i(id_ex_flush),
        .d_i(id_ex_d), .q_o(id_ex_q)
    );

    execute_stage u_execute (
        .id_ex_i(id_ex_q), .fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
        .mem_result_i(mem_wb_d.result), .wb_result_i(mem_wb_q.result),
        .ex_mem_o(ex_mem_d), .pcmux_sel_o(pcmux_sel), .target_o(target),
        .redirect_o(redirect)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .arst_n_i(arst_n_i), .load_i(!freeze), .flush_i(1'b0),
        .d_i(ex_mem_d), .q_o(ex_mem_q)
    );

    mem_stage u_mem (
        .ex_mem_i(ex_mem_q), .d_mem_rdata_i(d_mem_rdata_i),
        .d_mem_address_o(d_mem_address_o), .d_mem_wdata_o(d_mem_wdata_o),
        .d_mem_read_o(d_mem_read_o), .d_mem_write_o(d_mem_write_o),
        .d_mbe_o(d_mbe_o), .mem_wb_o(mem_wb_d)
    );

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .arst_n_i(arst_n_i), .load_i(!freeze), .flush_i(1'b0),
        .d_i(mem_wb_d), .q_o(mem_wb_q)
    );

    hazard_unit u_hazard (
        .clk(clk), .arst_n_i(arst_n_i), .id_rs1_i(id_rs1), .id_rs2_i(id_rs2),
        .id_ex_i(id_ex_q), .ex_mem_i(ex_mem_q), .mem_wb_i(mem_wb_q),
        .i_mem_read_i(i_mem_read_o), .i_mem_resp_i(i_mem_resp_i),
        .d_mem_read_i(d_mem_read_o), .d_mem_write_i(d_mem_write_o),
        .d_mem_resp_i(d_mem_resp_i),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .stall_o(stall), .freeze_o(freeze)
    );

endmodule

/* logic/hazard_unit.sv */
module hazard_unit (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic [4:0]               id_rs1_i,
    input  logic [4:0]               id_rs2_i,
    input  pipe_ctrl_pkg::id_ex_t    id_ex_i,
    input  pipe_ctrl_pkg::ex_mem_t   ex_mem_i,
    input  pipe_ctrl_pkg::mem_wb_t   mem_wb_i,
    input  logic                     i_mem_read_i,
    input  logic                     i_mem_resp_i,
    input  logic                     d_mem_read_i,
    input  logic                     d_mem_write_i,
    input  logic                     d_mem_resp_i,
    output pipe_ctrl_pkg::fwd_sel_t  fwd_a_o,
    output pipe_ctrl_pkg::fwd_sel_t  fwd_b_o,
    output logic                     stall_o,
    output logic                     freeze_o
);

    import pipe_ctrl_pkg::*;

    // nearest older writer wins
    function automatic fwd_sel_t pick(input logic [4:0] rs, input ex_mem_t mem,
                                      input mem_wb_t wb);
        if (rs != 5'd0 && mem.ctrl.load_regfile && mem.rd == rs) begin
            return fwd_mem;
        end
        if (rs != 5'd0 && wb.load_regfile && wb.rd == rs) begin
            return fwd_wb;
        end
        return fwd_rf;
    endfunction

    assign fwd_a_o = pick(id_ex_i.rs1, ex_mem_i, mem_wb_i);
    assign fwd_b_o = pick(id_ex_i.rs2, ex_mem_i, mem_wb_i);

    // load in EX feeding the instruction in ID
    assign stall_o = id_ex_i.ctrl.mem_read && id_ex_i.rd != 5'd0 &&
                     (id_ex_i.rd == id_rs1_i || id_ex_i.rd == id_rs2_i);

    assign freeze_o = (i_mem_read_i && !i_mem_resp_i) ||
                      ((d_mem_read_i || d_mem_write_i) && !d_mem_resp_i);

    // the load-use bubble keeps a load in MEM from feeding EX directly
    a_no_load_fwd: assert property (@(posedge clk) disable iff (!arst_n_i)
        (fwd_a_o == fwd_mem || fwd_b_o == fwd_mem) |-> !ex_mem_i.ctrl.mem_read);

    // one bubble is enough once the load leaves EX
    a_stall_once: assert property (@(posedge clk) disable iff (!arst_n_i)
        (stall_o && !freeze_o) |=> !stall_o);

endmodule

/* logic/mem_stage.sv */
module mem_stage (
    input  pipe_ctrl_pkg::ex_mem_t ex_mem_i,
    input  rv32i_types::rv32i_word d_mem_rdata_i,
    output rv32i_types::rv32i_word d_mem_address_o,
    output rv32i_types::rv32i_word d_mem_wdata_o,
    output logic                   d_mem_read_o,
    output logic                   d_mem_write_o,
    output logic [3:0]             d_mbe_o,
    output pipe_ctrl_pkg::mem_wb_t mem_wb_o
);

    import rv32i_types::*;

    logic [1:0] byte_sel;
    logic [7:0] ld_byte;
    rv32i_word  load_val;

    assign byte_sel        = ex_mem_i.alu_out[1:0];
    assign d_mem_address_o = {ex_mem_i.alu_out[31:2], 2'b00};
    assign d_mem_read_o    = ex_mem_i.ctrl.mem_read;
    assign d_mem_write_o   = ex_mem_i.ctrl.mem_write;

    // byte stores put the byte in every lane, mbe picks the lane
    assign d_mem_wdata_o = ex_mem_i.ctrl.mem_byte ? {4{ex_mem_i.store_data[7:0]}}
                                                  : ex_mem_i.store_data;
    assign d_mbe_o = ex_mem_i.ctrl.mem_byte ? (4'b0001 << byte_sel) : 4'b1111;

    assign ld_byte = d_mem_rdata_i[{byte_sel, 3'b000} +: 8];

    always_comb begin
        if (!ex_mem_i.ctrl.mem_byte) begin
            load_val = d_mem_rdata_i;
        end else if (ex_mem_i.ctrl.mem_unsigned) begin
            load_val = {24'b0, ld_byte};
        end else begin
            load_val = {{24{ld_byte[7]}}, ld_byte};
        end
    end

    always_comb begin
        case (ex_mem_i.ctrl.res_src)
            res_mem: mem_wb_o.result = load_val;
            res_pc4: mem_wb_o.result = ex_mem_i.pc_plus4;
            default: mem_wb_o.result = ex_mem_i.alu_out;
        endcase
    end

    assign mem_wb_o.rd           = ex_mem_i.rd;
    assign mem_wb_o.load_regfile = ex_mem_i.ctrl.load_regfile;

endmodule

/* logic/execute_stage.sv */
module execute_stage (
    input  pipe_ctrl_pkg::id_ex_t     id_ex_i,
    input  pipe_ctrl_pkg::fwd_sel_t   fwd_a_i,
    input  pipe_ctrl_pkg::fwd_sel_t   fwd_b_i,
    input  rv32i_types::rv32i_word    mem_result_i,
    input  rv32i_types::rv32i_word    wb_result_i,
    output pipe_ctrl_pkg::ex_mem_t    ex_mem_o,
    output pipe_ctrl_pkg::pcmux_sel_t pcmux_sel_o,
    output rv32i_types::rv32i_word    target_o,
    output logic                      redirect_o
);

    import rv32i_types::*;
    import pipe_ctrl_pkg::*;

    rv32i_word op_a;
    rv32i_word op_b;
    rv32i_word alu_a;
    rv32i_word alu_b;
    rv32i_word alu_out;
    logic      taken;

    function automatic rv32i_word fwd_mux(input fwd_sel_t sel, input rv32i_word rf,
                                          input rv32i_word mem, input rv32i_word wb);
        case (sel)
            fwd_mem: return mem;
            fwd_wb:  return wb;
            default: return rf;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a_i, id_ex_i.rs1_val, mem_result_i, wb_result_i);
    assign op_b  = fwd_mux(fwd_b_i, id_ex_i.rs2_val, mem_result_i, wb_result_i);
    assign alu_a = id_ex_i.ctrl.alu_pc ? id_ex_i.pc : op_a;
    assign alu_b = id_ex_i.ctrl.alu_imm ? id_ex_i.imm : op_b;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            alu_sub:  alu_out = alu_a - alu_b;
            alu_and:  alu_out = alu_a & alu_b;
            alu_or:   alu_out = alu_a | alu_b;
            alu_xor:  alu_out = alu_a ^ alu_b;
            alu_slt:  alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
            alu_sltu: alu_out = {31'b0, alu_a < alu_b};
            alu_sll:  alu_out = alu_a << alu_b[4:0];
            alu_srl:  alu_out = alu_a >> alu_b[4:0];
            alu_sra:  alu_out = $signed(alu_a) >>> alu_b[4:0];
            default:  alu_out = alu_a + alu_b;
        endcase
    end

    // beq, bne, blt, bge only
    always_comb begin
        case (id_ex_i.ctrl.br_cond)
            3'b000:  taken = (op_a == op_b);
            3'b001:  taken = (op_a != op_b);
            3'b100:  taken = $signed(op_a) < $signed(op_b);
            3'b101:  taken = $signed(op_a) >= $signed(op_b);
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o  = (id_ex_i.ctrl.is_branch && taken) || id_ex_i.ctrl.is_jump;
    assign pcmux_sel_o = redirect_o ? pc_target : pc_plus4;
    assign target_o    = id_ex_i.pc + id_ex_i.imm;

    assign ex_mem_o.ctrl       = id_ex_i.ctrl;
    assign ex_mem_o.alu_out    = alu_out;
    assign ex_mem_o.store_data = op_b;
    assign ex_mem_o.pc_plus4   = id_ex_i.pc + 32'd4;
    assign ex_mem_o.rd         = id_ex_i.rd;

endmodule

/* logic/decode_stage.sv */
module decode_stage (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  pipe_ctrl_pkg::if_id_t  if_id_i,
    input  pipe_ctrl_pkg::mem_wb_t wb_i,
    output pipe_ctrl_pkg::id_ex_t  id_ex_o,
    output logic [4:0]             rs1_o,
    output logic [4:0]             rs2_o
);

    import rv32i_types::*;

    rv32i_word         instr;
    rv32i_word         regs [32];
    rv32i_word         imm;
    rv32i_control_word ctrl;
    logic              use_rs1;
    logic              use_rs2;
    logic [4:0]        rs1_idx;
    logic [4:0]        rs2_idx;
    logic [2:0]        funct3;

    function automatic alu_op_t alu_fn(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign instr  = if_id_i.instr;
    assign funct3 = instr[14:12];

    always_comb begin
        ctrl    = '0;
        imm     = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (instr[6:0])
            op_lui: begin
                ctrl.alu_imm      = 1'b1;
                ctrl.load_regfile = 1'b1;
                imm               = {instr[31:12], 12'h000};
            end
            op_auipc: begin
                ctrl.alu_imm      = 1'b1;
                ctrl.alu_pc       = 1'b1;
                ctrl.load_regfile = 1'b1;
                imm               = {instr[31:12], 12'h000};
            end
            op_jal: begin
                ctrl.is_jump      = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.res_src      = res_pc4;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            op_br: begin
                ctrl.is_branch = 1'b1;
                ctrl.br_cond   = funct3;
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            op_load: begin
                ctrl.alu_imm      = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.mem_byte     = (funct3[1:0] == 2'b00);
                ctrl.mem_unsigned = funct3[2];
                ctrl.load_regfile = 1'b1;
                ctrl.res_src      = res_mem;
                use_rs1           = 1'b1;
                imm               = {{20{instr[31]}}, instr[31:20]};
            end
            op_store: begin
                ctrl.alu_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.mem_byte  = (funct3[1:0] == 2'b00);
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            op_imm: begin
                // bit 30 only selects sra here, addi uses it as immediate
                ctrl.alu_op       = alu_fn(funct3, (funct3 == 3'b101) && instr[30]);
                ctrl.alu_imm      = 1'b1;
                ctrl.load_regfile = 1'b1;
                use_rs1           = 1'b1;
                imm               = {{20{instr[31]}}, instr[31:20]};
            end
            op_reg: begin
                ctrl.alu_op       = alu_fn(funct3, instr[30]);
                ctrl.load_regfile = 1'b1;
                use_rs1           = 1'b1;
                use_rs2           = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // unused source fields read as x0 so they never forward or stall
    assign rs1_idx = use_rs1 ? instr[19:15] : 5'd0;
    assign rs2_idx = use_rs2 ? instr[24:20] : 5'd0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.load_regfile && wb_i.rd != 5'd0) begin
            regs[wb_i.rd] <= wb_i.result;
        end
    end

    // write-through so WB and ID can share a cycle
    assign id_ex_o.rs1_val = (rs1_idx == 5'd0) ? '0 :
        (wb_i.load_regfile && wb_i.rd == rs1_idx) ? wb_i.result : regs[rs1_idx];
    assign id_ex_o.rs2_val = (rs2_idx == 5'd0) ? '0 :
        (wb_i.load_regfile && wb_i.rd == rs2_idx) ? wb_i.result : regs[rs2_idx];

    assign id_ex_o.ctrl = ctrl;
    assign id_ex_o.pc   = if_id_i.pc;
    assign id_ex_o.imm  = imm;
    assign id_ex_o.rs1  = rs1_idx;
    assign id_ex_o.rs2  = rs2_idx;
    assign id_ex_o.rd   = instr[11:7];
    assign rs1_o        = rs1_idx;
    assign rs2_o        = rs2_idx;

endmodule

/* logic/fetch_stage.sv */
module fetch_stage #(
    parameter rv32i_types::rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      hold_i,
    input  pipe_ctrl_pkg::pcmux_sel_t pcmux_sel_i,
    input  rv32i_types::rv32i_word    target_i,
    input  rv32i_types::rv32i_word    i_mem_rdata_i,
    output rv32i_types::rv32i_word    i_mem_address_o,
    output logic                      i_mem_read_o,
    output pipe_ctrl_pkg::if_id_t     if_id_o
);

    import rv32i_types::*;
    import pipe_ctrl_pkg::*;

    rv32i_word pc_q;
    rv32i_word pc_next;

    assign pc_next = (pcmux_sel_i == pc_target) ? target_i : pc_q + 32'd4;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (!hold_i) begin
            pc_q <= pc_next;
        end
    end

    // fetch runs every cycle, freeze covers the wait
    assign i_mem_read_o    = 1'b1;
    assign i_mem_address_o = pc_q;
    assign if_id_o.pc      = pc_q;
    assign if_id_o.instr   = i_mem_rdata_i;

endmodule

/* logic/pipe_reg.sv */
module pipe_reg #(
    parameter type      payload_t = logic [31:0],
    parameter payload_t BUBBLE    = '0
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     load_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= BUBBLE;
        end else if (flush_i) begin
            q_o <= BUBBLE;
        end else if (load_i) begin
            q_o <= d_i;
        end
    end

    // a redirect never meets a load-use stall in the same stage
    a_flush_needs_load: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |-> load_i)
        else $error("pipe_reg flushed while held");

endmodule

/* logic/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    import rv32i_types::*;

    typedef enum logic {
        pc_plus4,
        pc_target
    } pcmux_sel_t;

    typedef enum logic [1:0] {
        fwd_rf,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    typedef struct packed {
        rv32i_word pc;
        rv32i_word instr;
    } if_id_t;

    typedef struct packed {
        rv32i_control_word ctrl;
        rv32i_word         pc;
        rv32i_word         rs1_val;
        rv32i_word         rs2_val;
        rv32i_word         imm;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [4:0]        rd;
    } id_ex_t;

    typedef struct packed {
        rv32i_control_word ctrl;
        rv32i_word         alu_out;
        rv32i_word         store_data;
        rv32i_word         pc_plus4;
        logic [4:0]        rd;
    } ex_mem_t;

    typedef struct packed {
        rv32i_word  result;
        logic [4:0] rd;
        logic       load_regfile;
    } mem_wb_t;

endpackage

/* logic/rv32i_types.sv */
package rv32i_types;

    typedef logic [31:0] rv32i_word;

    // base opcodes the core decodes, anything else becomes a bubble
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

    // source of the value written back
    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_pc4
    } res_src_t;

    // all zero is a bubble: add, no writes, no memory access
    typedef struct packed {
        alu_op_t    alu_op;
        logic       alu_imm;
        logic       alu_pc;
        logic       mem_read;
        logic       mem_write;
        logic       mem_byte;
        logic       mem_unsigned;
        logic       load_regfile;
        res_src_t   res_src;
        logic       is_branch;
        logic [2:0] br_cond;
        logic       is_jump;
    } rv32i_control_word;

endpackage
